// File: mipsControl.f
+incdir+testbench
hw/mipsControlPkg.sv
hw/instrDecoder.sv
hw/stateSequencer.sv
hw/controlWordGen.sv
hw/controlUnit.sv
testbench/controlUnitTb.sv

// File: Bender.yml
package:
  name: mipsControl

sources:
  - hw/mipsControlPkg.sv
  - hw/instrDecoder.sv
  - hw/stateSequencer.sv
  - hw/controlWordGen.sv
  - hw/controlUnit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/controlUnitTb.sv

// File: testbench/controlUnitModel.svh
`ifndef CONTROL_UNIT_MODEL_SVH
`define CONTROL_UNIT_MODEL_SVH

// One value per control output of the DUT
typedef struct packed {
	logic      pcWrite;
	logic      irWrite;
	logic      writeRegA;
	logic      writeRegB;
	logic      aluOutControl;
	logic      regWrite;
	logic      shiftSrc;
	logic      shiftAmt;
	pcSourceT  pcSource;
	aluSrcAT   aluSrcA;
	aluSrcBT   aluSrcB;
	aluOpT     aluOp;
	shiftCtrlT shiftCtrl;
	regDstT    regDst;
	memToRegT  memToReg;
} ctrlWordT;

typedef struct packed {
	opClassT   cls;
	aluOpT     alu;
	shiftCtrlT sh;
} decodedT;

function automatic decodedT decodeModel(input opcodeT opc, input functT fn);
	decodedT d;
	d.cls = OP_NONE;
	d.alu = ALU_PASS;
	d.sh = SH_NONE;
	if (opc == OPC_ADDI || opc == OPC_ADDIU) begin
		d.cls = OP_ADDI;
		d.alu = ALU_ADD;
	end else if (opc == OPC_LUI) begin
		d.cls = OP_LUI;
	end else if (opc == OPC_RTYPE) begin
		if (fn == FN_ADD || fn == FN_SUB || fn == FN_AND) begin
			d.cls = OP_ALU_REG;
			d.alu = (fn == FN_ADD) ? ALU_ADD : (fn == FN_SUB) ? ALU_SUB : ALU_AND;
		end else if (fn == FN_SRL || fn == FN_SRA) begin
			d.cls = OP_SHIFT;
			d.sh = (fn == FN_SRL) ? SH_SRL : SH_SRA;
		end else if (fn == FN_XCHG) begin
			d.cls = OP_XCHG;
		end else if (fn == FN_BREAK) begin
			d.cls = OP_BREAK;
			d.alu = ALU_SUB;
		end
	end
	return d;
endfunction

function automatic stateT expectedNextState(input stateT st, input opClassT cls);
	case (st)
		FETCH: return WAITFETCH;
		WAITFETCH: return WAITFETCH2;
		WAITFETCH2: return DECODE;
		DECODE: return OPERATE;
		OPERATE: begin
			if (cls == OP_BREAK) begin
				return FETCH;
			end else if (cls == OP_LUI || cls == OP_NONE) begin
				return WAIT;
			end
			return WRITEBACK;
		end
		WRITEBACK: return WAIT;
		default: return FETCH;
	endcase
endfunction

// Cycles from FETCH back to FETCH
function automatic int instrLength(input opClassT cls);
	stateT s;
	int n;
	s = expectedNextState(FETCH, cls);
	n = 1;
	while (s != FETCH) begin
		s = expectedNextState(s, cls);
		n++;
	end
	return n;
endfunction

function automatic ctrlWordT stackPointerWord();
	ctrlWordT w;
	w = '0;
	w.regWrite = 1'b1;
	w.regDst = DST_SP;
	w.memToReg = WB_SPINIT;
	return w;
endfunction

function automatic ctrlWordT expectedControls(input stateT st, input opClassT cls,
		input aluOpT aluFunc, input shiftCtrlT shiftFunc);
	ctrlWordT w;
	// All-zero is the inactive word for every field
	w = '0;
	case (st)
		FETCH: w.aluSrcB = SRCB_FOUR;
		WAITFETCH2: w.irWrite = 1'b1;
		DECODE: begin
			w.writeRegA = 1'b1;
			w.writeRegB = 1'b1;
			w.aluSrcB = SRCB_BRANCH;
			w.aluOp = ALU_ADD;
			w.aluOutControl = 1'b1;
			w.shiftCtrl = SH_LOAD;
			w.shiftSrc = 1'b1;
		end
		OPERATE: begin
			if (cls == OP_ALU_REG || cls == OP_ADDI) begin
				w.aluSrcA = SRCA_REGA;
				w.aluOp = aluFunc;
				w.aluOutControl = 1'b1;
				if (cls == OP_ADDI) begin
					w.aluSrcB = SRCB_IMM;
				end
			end else if (cls == OP_SHIFT) begin
				w.shiftAmt = 1'b1;
				w.shiftCtrl = shiftFunc;
			end else if (cls == OP_LUI) begin
				w.regWrite = 1'b1;
				w.regDst = DST_RT;
				w.memToReg = WB_LUI;
			end else if (cls == OP_BREAK) begin
				w.pcWrite = 1'b1;
				w.pcSource = PCSRC_ALUOUT;
				w.aluSrcB = SRCB_FOUR;
				w.aluOp = aluFunc;
			end
		end
		WRITEBACK: begin
			w.regWrite = 1'b1;
			w.regDst = (cls == OP_ADDI) ? DST_RT : DST_RD;
			w.memToReg = (cls == OP_SHIFT) ? WB_SHIFT : (cls == OP_XCHG) ? WB_REGA : WB_ALUOUT;
		end
		default: begin
		end
	endcase
	return w;
endfunction

function automatic logic [31:0] nextRandom(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: testbench/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb import mipsControlPkg::*; ();

	`include "controlUnitModel.svh"

	localparam int RESET_CYCLES = 4;
	localparam int NUM_INSTR = 51;
	localparam int CYCLE_LIMIT = (NUM_INSTR * 7 + RESET_CYCLES) * 3 / 2;

	logic      clock;
	logic      reset;
	opcodeT    Opcode;
	functT     Funct;
	logic      PCWrite;
	logic      IRWrite;
	logic      WriteRegA;
	logic      WriteRegB;
	logic      AluOutControl;
	logic      RegWrite;
	logic      ShiftSrc;
	logic      ShiftAmt;
	pcSourceT  PCSource;
	aluSrcAT   AluSrcA;
	aluSrcBT   AluSrcB;
	aluOpT     AluOp;
	shiftCtrlT ShiftCtrl;
	regDstT    RegDst;
	memToRegT  MemToReg;
	stateT     state;

	stateT       modelState;
	ctrlWordT    expectedWord;
	decodedT     modelDec;
	logic        modelValid = 1'b0;
	int          errorCount = 0;
	int          checkCount = 0;
	int          testCount = 0;
	int          testErrors = 0;
	int          cycleCount = 0;
	logic [31:0] rngState = 32'h3c26_c69a;

	// Kept pairs for the random mix with arbitrary I-type funct values
	opcodeT keptOpcodes[10] = '{OPC_RTYPE, OPC_RTYPE, OPC_RTYPE, OPC_RTYPE, OPC_RTYPE,
		OPC_RTYPE, OPC_RTYPE, OPC_ADDI, OPC_ADDIU, OPC_LUI};
	functT keptFuncts[10] = '{FN_ADD, FN_SUB, FN_AND, FN_SRL, FN_SRA,
		FN_XCHG, FN_BREAK, 6'h2a, 6'h11, 6'h3f};
	stateT fetchSteps[4] = '{FETCH, WAITFETCH, WAITFETCH2, DECODE};

	controlUnit u_controlUnit (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Error: %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
				$time);
		end
	endtask

	// Reference model stepping on the DUT's clock edge
	always @(posedge clock) begin
		modelDec = decodeModel(Opcode, Funct);
		if (reset) begin
			modelState <= FETCH;
			expectedWord <= stackPointerWord();
		end else begin
			expectedWord <= expectedControls(modelState, modelDec.cls, modelDec.alu,
				modelDec.sh);
			modelState <= expectedNextState(modelState, modelDec.cls);
		end
		modelValid <= 1'b1;
	end

	always @(negedge clock) begin
		if (modelValid) begin
			checkValue("state", modelState, state);
			checkValue("PCWrite", expectedWord.pcWrite, PCWrite);
			checkValue("IRWrite", expectedWord.irWrite, IRWrite);
			checkValue("WriteRegA", expectedWord.writeRegA, WriteRegA);
			checkValue("WriteRegB", expectedWord.writeRegB, WriteRegB);
			checkValue("AluOutControl", expectedWord.aluOutControl, AluOutControl);
			checkValue("RegWrite", expectedWord.regWrite, RegWrite);
			checkValue("ShiftSrc", expectedWord.shiftSrc, ShiftSrc);
			checkValue("ShiftAmt", expectedWord.shiftAmt, ShiftAmt);
			checkValue("PCSource", expectedWord.pcSource, PCSource);
			checkValue("AluSrcA", expectedWord.aluSrcA, AluSrcA);
			checkValue("AluSrcB", expectedWord.aluSrcB, AluSrcB);
			checkValue("AluOp", expectedWord.aluOp, AluOp);
			checkValue("ShiftCtrl", expectedWord.shiftCtrl, ShiftCtrl);
			checkValue("RegDst", expectedWord.regDst, RegDst);
			checkValue("MemToReg", expectedWord.memToReg, MemToReg);
		end
	end

	initial begin
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Run timed out after %0d cycles without finishing the tests", cycleCount);
		$display("** FAIL **");
		$finish;
	end

	task automatic startTest();
		testErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("Test %-8s finished with %0d errors", name, errorCount - testErrors);
	endtask

	// Starts at a falling edge with the DUT in FETCH, ends at the next one
	task automatic runInstr(input opcodeT opc, input functT fn);
		decodedT d;
		int cycles;
		d = decodeModel(opc, fn);
		@(posedge clock);
		Opcode <= opc;
		Funct <= fn;
		cycles = 1;
		@(negedge clock);
		while (state !== FETCH) begin
			cycles++;
			@(negedge clock);
		end
		checkValue("instruction cycles", instrLength(d.cls), cycles);
	endtask

	task automatic drawPair(output opcodeT opc, output functT fn);
		int idx;
		rngState = nextRandom(rngState);
		idx = rngState[19:16] % 10;
		case (rngState[31:30])
			2'd0: begin
				opc = keptOpcodes[idx];
				fn = keptFuncts[idx];
			end
			2'd1: begin
				opc = OPC_RTYPE;
				fn = rngState[13:8];
			end
			default: begin
				opc = rngState[25:20];
				fn = rngState[13:8];
			end
		endcase
	endtask

	initial begin
		int cycles;
		opcodeT opc;
		functT fn;
		reset = 1'b1;
		Opcode = OPC_RTYPE;
		Funct = 6'h00;

		// Reset word, then a no-op through the fetch steps
		startTest();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clock);
			if (i == RESET_CYCLES - 1) begin
				reset <= 1'b0;
			end
			@(negedge clock);
			checkValue("state", FETCH, state);
			checkValue("RegWrite", 1'b1, RegWrite);
			checkValue("RegDst", DST_SP, RegDst);
			checkValue("MemToReg", WB_SPINIT, MemToReg);
		end
		for (int k = 1; k < 4; k++) begin
			@(negedge clock);
			checkValue("state", fetchSteps[k], state);
			checkValue("IRWrite", k == 3, IRWrite);
		end
		cycles = 4;
		@(negedge clock);
		while (state !== FETCH) begin
			cycles++;
			@(negedge clock);
		end
		checkValue("instruction cycles", 6, cycles);
		endTest("reset");

		startTest();
		runInstr(OPC_RTYPE, FN_ADD);
		runInstr(OPC_RTYPE, FN_SUB);
		runInstr(OPC_RTYPE, FN_AND);
		endTest("alu");

		startTest();
		runInstr(OPC_RTYPE, FN_SRL);
		runInstr(OPC_RTYPE, FN_SRA);
		endTest("shift");

		startTest();
		runInstr(OPC_ADDI, 6'h15);
		runInstr(OPC_ADDIU, 6'h2c);
		runInstr(OPC_LUI, 6'h07);
		endTest("imm");

		startTest();
		runInstr(OPC_RTYPE, FN_XCHG);
		runInstr(OPC_RTYPE, FN_BREAK);
		endTest("xchg/brk");

		startTest();
		repeat (40) begin
			drawPair(opc, fn);
			runInstr(opc, fn);
		end
		endTest("random");

		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount,
			errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import mipsControlPkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  opcodeT    Opcode,
	input  functT     Funct,
	output logic      PCWrite,
	output logic      IRWrite,
	output logic      WriteRegA,
	output logic      WriteRegB,
	output logic      AluOutControl,
	output logic      RegWrite,
	output logic      ShiftSrc,
	output logic      ShiftAmt,
	output pcSourceT  PCSource,
	output aluSrcAT   AluSrcA,
	output aluSrcBT   AluSrcB,
	output aluOpT     AluOp,
	output shiftCtrlT ShiftCtrl,
	output regDstT    RegDst,
	output memToRegT  MemToReg,
	output stateT     state
);

	opClassT   opClass;
	aluOpT     aluFunc;
	shiftCtrlT shiftFunc;

	instrDecoder u_instrDecoder (
		.Opcode    (Opcode),
		.Funct     (Funct),
		.opClass   (opClass),
		.aluFunc   (aluFunc),
		.shiftFunc (shiftFunc)
	);

	stateSequencer u_stateSequencer (
		.clock   (clock),
		.reset   (reset),
		.opClass (opClass),
		.state   (state)
	);

	controlWordGen u_controlWordGen (
		.clock         (clock),
		.reset         (reset),
		.state         (state),
		.opClass       (opClass),
		.aluFunc       (aluFunc),
		.shiftFunc     (shiftFunc),
		.PCWrite       (PCWrite),
		.IRWrite       (IRWrite),
		.WriteRegA     (WriteRegA),
		.WriteRegB     (WriteRegB),
		.AluOutControl (AluOutControl),
		.RegWrite      (RegWrite),
		.ShiftSrc      (ShiftSrc),
		.ShiftAmt      (ShiftAmt),
		.PCSource      (PCSource),
		.AluSrcA       (AluSrcA),
		.AluSrcB       (AluSrcB),
		.AluOp         (AluOp),
		.ShiftCtrl     (ShiftCtrl),
		.RegDst        (RegDst),
		.MemToReg      (MemToReg)
	);

endmodule

// File: hw/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen import mipsControlPkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  stateT     state,
	input  opClassT   opClass,
	input  aluOpT     aluFunc,
	input  shiftCtrlT shiftFunc,
	output logic      PCWrite,
	output logic      IRWrite,
	output logic      WriteRegA,
	output logic      WriteRegB,
	output logic      AluOutControl,
	output logic      RegWrite,
	output logic      ShiftSrc,
	output logic      ShiftAmt,
	output pcSourceT  PCSource,
	output aluSrcAT   AluSrcA,
	output aluSrcBT   AluSrcB,
	output aluOpT     AluOp,
	output shiftCtrlT ShiftCtrl,
	output regDstT    RegDst,
	output memToRegT  MemToReg
);

	// Class held from OPERATE for the write-back step
	opClassT opClassQ;

	always_ff @(posedge clock) begin
		if (state == OPERATE) begin
			opClassQ <= opClass;
		end
	end

	always_ff @(posedge clock) begin
		PCWrite       <= 1'b0;
		IRWrite       <= 1'b0;
		WriteRegA     <= 1'b0;
		WriteRegB     <= 1'b0;
		AluOutControl <= 1'b0;
		RegWrite      <= 1'b0;
		ShiftSrc      <= 1'b0;
		ShiftAmt      <= 1'b0;
		PCSource      <= PCSRC_ALU;
		AluSrcA       <= SRCA_PC;
		AluSrcB       <= SRCB_REGB;
		AluOp         <= ALU_PASS;
		ShiftCtrl     <= SH_NONE;
		RegDst        <= DST_NONE;
		MemToReg      <= WB_REGA;

		if (reset) begin
			// Load the initial stack pointer
			RegWrite <= 1'b1;
			RegDst   <= DST_SP;
			MemToReg <= WB_SPINIT;
		end else begin
			case (state)
				FETCH: begin
					AluSrcB <= SRCB_FOUR;
				end
				WAITFETCH2: begin
					IRWrite <= 1'b1;
				end
				DECODE: begin
					// Read rs/rt and precompute the branch target
					WriteRegA     <= 1'b1;
					WriteRegB     <= 1'b1;
					AluSrcB       <= SRCB_BRANCH;
					AluOp         <= ALU_ADD;
					AluOutControl <= 1'b1;
					ShiftCtrl     <= SH_LOAD;
					ShiftSrc      <= 1'b1;
				end
				OPERATE: begin
					case (opClass)
						OP_ALU_REG: begin
							AluSrcA       <= SRCA_REGA;
							AluOp         <= aluFunc;
							AluOutControl <= 1'b1;
						end
						OP_ADDI: begin
							AluSrcA       <= SRCA_REGA;
							AluSrcB       <= SRCB_IMM;
							AluOp         <= aluFunc;
							AluOutControl <= 1'b1;
						end
						OP_SHIFT: begin
							ShiftAmt  <= 1'b1;
							ShiftCtrl <= shiftFunc;
						end
						OP_LUI: begin
							RegWrite <= 1'b1;
							RegDst   <= DST_RT;
							MemToReg <= WB_LUI;
						end
						OP_BREAK: begin
							PCWrite  <= 1'b1;
							PCSource <= PCSRC_ALUOUT;
							AluSrcB  <= SRCB_FOUR;
							AluOp    <= aluFunc;
						end
						default: begin
						end
					endcase
				end
				WRITEBACK: begin
					RegWrite <= 1'b1;
					case (opClassQ)
						OP_ADDI: begin
							RegDst   <= DST_RT;
							MemToReg <= WB_ALUOUT;
						end
						OP_SHIFT: begin
							RegDst   <= DST_RD;
							MemToReg <= WB_SHIFT;
						end
						OP_XCHG: begin
							RegDst   <= DST_RD;
							MemToReg <= WB_REGA;
						end
						default: begin
							RegDst   <= DST_RD;
							MemToReg <= WB_ALUOUT;
						end
					endcase
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: hw/stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer import mipsControlPkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  opClassT opClass,
	output stateT   state
);

	stateT nextState;

	always_comb begin
		nextState = FETCH;

		case (state)
			FETCH: begin
				nextState = WAITFETCH;
			end
			WAITFETCH: begin
				nextState = WAITFETCH2;
			end
			WAITFETCH2: begin
				nextState = DECODE;
			end
			DECODE: begin
				nextState = OPERATE;
			end
			OPERATE: begin
				case (opClass)
					OP_ALU_REG, OP_SHIFT, OP_ADDI, OP_XCHG: begin
						nextState = WRITEBACK;
					end
					OP_BREAK: begin
						// Straight back to fetch at the new PC
						nextState = FETCH;
					end
					default: begin
						// LUI and no-ops
						nextState = WAIT;
					end
				endcase
			end
			WRITEBACK: begin
				nextState = WAIT;
			end
			WAIT: begin
				nextState = FETCH;
			end
			default: begin
				nextState = FETCH;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH;
		end else begin
			state <= nextState;
		end
	end

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import mipsControlPkg::*; (
	input  opcodeT    Opcode,
	input  functT     Funct,
	output opClassT   opClass,
	output aluOpT     aluFunc,
	output shiftCtrlT shiftFunc
);

	always_comb begin
		opClass   = OP_NONE;
		aluFunc   = ALU_PASS;
		shiftFunc = SH_NONE;

		case (Opcode)
			OPC_ADDI, OPC_ADDIU: begin
				// ADDIU takes the same path as ADDI
				opClass = OP_ADDI;
				aluFunc = ALU_ADD;
			end
			OPC_LUI: begin
				opClass = OP_LUI;
			end
			OPC_RTYPE: begin
				case (Funct)
					FN_ADD: begin
						opClass = OP_ALU_REG;
						aluFunc = ALU_ADD;
					end
					FN_SUB: begin
						opClass = OP_ALU_REG;
						aluFunc = ALU_SUB;
					end
					FN_AND: begin
						opClass = OP_ALU_REG;
						aluFunc = ALU_AND;
					end
					FN_SRL: begin
						opClass   = OP_SHIFT;
						shiftFunc = SH_SRL;
					end
					FN_SRA: begin
						opClass   = OP_SHIFT;
						shiftFunc = SH_SRA;
					end
					FN_XCHG: begin
						opClass = OP_XCHG;
					end
					FN_BREAK: begin
						// PC minus four through the ALU
						opClass = OP_BREAK;
						aluFunc = ALU_SUB;
					end
					default: begin
						opClass = OP_NONE;
					end
				endcase
			end
			default: begin
				// Unsupported opcodes fall through as no-ops
				opClass = OP_NONE;
			end
		endcase
	end

endmodule

// File: hw/mipsControlPkg.sv
package mipsControlPkg;

	// Steps of the multicycle sequence
	typedef enum logic [6:0] {
		FETCH      = 7'b0000000,
		WAITFETCH  = 7'b0000001,
		WAITFETCH2 = 7'b0000010,
		DECODE     = 7'b0000011,
		OPERATE    = 7'b0000100,
		WRITEBACK  = 7'b0000101,
		WAIT       = 7'b1111111
	} stateT;

	// Decoded instruction classes
	typedef enum logic [2:0] {
		OP_ALU_REG = 3'd0,
		OP_SHIFT   = 3'd1,
		OP_ADDI    = 3'd2,
		OP_LUI     = 3'd3,
		OP_XCHG    = 3'd4,
		OP_BREAK   = 3'd5,
		OP_NONE    = 3'd6
	} opClassT;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// Opcode field
	localparam opcodeT OPC_RTYPE = 6'b000000;
	localparam opcodeT OPC_ADDI  = 6'b001000;
	localparam opcodeT OPC_ADDIU = 6'b001001;
	localparam opcodeT OPC_LUI   = 6'b001111;

	// Funct field of R-type instructions
	localparam functT FN_ADD   = 6'b100000;
	localparam functT FN_SUB   = 6'b100010;
	localparam functT FN_AND   = 6'b100100;
	localparam functT FN_SRL   = 6'b000010;
	localparam functT FN_SRA   = 6'b000011;
	localparam functT FN_XCHG  = 6'b000101;
	localparam functT FN_BREAK = 6'b001101;

	// ALU function
	typedef logic [2:0] aluOpT;

	localparam aluOpT ALU_PASS = 3'b000;
	localparam aluOpT ALU_ADD  = 3'b001;
	localparam aluOpT ALU_SUB  = 3'b010;
	localparam aluOpT ALU_AND  = 3'b011;

	// Shifter function
	typedef logic [2:0] shiftCtrlT;

	localparam shiftCtrlT SH_NONE = 3'b000;
	localparam shiftCtrlT SH_LOAD = 3'b001;
	localparam shiftCtrlT SH_SRL  = 3'b011;
	localparam shiftCtrlT SH_SRA  = 3'b100;

	// ALU input selects
	typedef logic [1:0] aluSrcAT;

	localparam aluSrcAT SRCA_PC   = 2'b00;
	localparam aluSrcAT SRCA_REGA = 2'b10;

	typedef logic [2:0] aluSrcBT;

	localparam aluSrcBT SRCB_REGB   = 3'b000;
	localparam aluSrcBT SRCB_FOUR   = 3'b001;
	localparam aluSrcBT SRCB_IMM    = 3'b010;
	localparam aluSrcBT SRCB_BRANCH = 3'b100;

	// PC source
	typedef logic [2:0] pcSourceT;

	localparam pcSourceT PCSRC_ALU    = 3'b000;
	localparam pcSourceT PCSRC_ALUOUT = 3'b001;

	// Register file destination
	typedef logic [2:0] regDstT;

	localparam regDstT DST_NONE = 3'b000;
	localparam regDstT DST_RT   = 3'b010;
	localparam regDstT DST_RD   = 3'b101;
	// SP shares its code with rd
	localparam regDstT DST_SP   = 3'b101;

	// Write-back data
	typedef logic [3:0] memToRegT;

	localparam memToRegT WB_REGA   = 4'b0000;
	localparam memToRegT WB_SHIFT  = 4'b0011;
	localparam memToRegT WB_ALUOUT = 4'b1000;
	localparam memToRegT WB_LUI    = 4'b1010;
	localparam memToRegT WB_SPINIT = 4'b1011;

endpackage
